/* common/pong_pkg.sv */
package pong_pkg;

    // counter value, one 4-bit word.
    typedef logic [3:0] count_t;

    // bounds as read from the switches.
    typedef struct packed {
        count_t max;
        count_t min;
    } bounds_t;

    // counter output, up is 1 while counting upward.
    typedef struct packed {
        count_t value;
        logic   up;
    } pong_state_t;

    // active low segment lines, bit 0 is segment a and bit 6 segment g.
    typedef logic [6:0] seg_t;

    // active low digit enables, exactly one low at a time.
    typedef logic [3:0] digit_sel_t;

endpackage

/* display/seg_scan.sv */
module seg_scan
    import pong_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        scan_tick,
    input  pong_state_t state,
    output seg_t        segment,
    output digit_sel_t  digit_sel
);

    // arrows light the upper or the lower half of the digit.
    localparam seg_t SEG_UP    = 7'b1011100;
    localparam seg_t SEG_DOWN  = 7'b1100011;
    localparam seg_t SEG_BLANK = 7'b1111111;

    count_t ones_digit;
    count_t tens_digit;
    seg_t   arrow;

    function automatic seg_t digit_to_seg(input count_t digit);
        seg_t pattern;
        case (digit)
            4'd0:    pattern = 7'b1000000;
            4'd1:    pattern = 7'b1111001;
            4'd2:    pattern = 7'b0100100;
            4'd3:    pattern = 7'b0110000;
            4'd4:    pattern = 7'b0011001;
            4'd5:    pattern = 7'b0010010;
            4'd6:    pattern = 7'b0000010;
            4'd7:    pattern = 7'b1111000;
            4'd8:    pattern = 7'b0000000;
            4'd9:    pattern = 7'b0010000;
            default: pattern = SEG_BLANK;
        endcase
        return pattern;
    endfunction

    // one digit is active, moving left on every scan tick.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digit_sel <= 4'b1110;
        end else if (scan_tick) begin
            digit_sel <= {digit_sel[2:0], digit_sel[3]};
        end
    end

    // split the 4-bit value into decimal tens and ones.
    always_comb begin
        if (state.value >= count_t'(10)) begin
            tens_digit = count_t'(1);
            ones_digit = state.value - count_t'(10);
        end else begin
            tens_digit = count_t'(0);
            ones_digit = state.value;
        end
    end

    assign arrow = state.up ? SEG_UP : SEG_DOWN;

    always_comb begin
        case (digit_sel)
            4'b1110: segment = arrow;
            4'b1101: segment = arrow;
            4'b1011: segment = digit_to_seg(ones_digit);
            4'b0111: segment = digit_to_seg(tens_digit);
            default: segment = SEG_BLANK;
        endcase
    end

    // rotation must keep a single active digit.
    property p_one_digit_active;
        @(posedge clk) disable iff (!rst_n)
        $onehot(~digit_sel);
    endproperty
    a_one_digit_active: assert property (p_one_digit_active)
        else $error("digit_sel not one-hot-zero: %b", digit_sel);

endmodule

/* hw/button_conditioner.sv */
module button_conditioner #(
    parameter int unsigned DEBOUNCE_LEN = 10
) (
    input  logic clk,
    input  logic rst_n,
    input  logic button,
    output logic pulse
);

    logic [DEBOUNCE_LEN-1:0] history;
    logic                    debounced;
    logic                    debounced_q;

    // level counts as pressed only after a full run of high samples.
    assign debounced = &history;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            history <= '0;
        end else begin
            history <= {history[DEBOUNCE_LEN-2:0], button};
        end
    end

    // rising edge of the debounced level gives one pulse per press.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            debounced_q <= 1'b0;
            pulse       <= 1'b0;
        end else begin
            debounced_q <= debounced;
            pulse       <= debounced & ~debounced_q;
        end
    end

endmodule

/* hw/pong_top.sv */
module pong_top
    import pong_pkg::*;
#(
    parameter int unsigned DEBOUNCE_LEN = 10,
    parameter int unsigned COUNT_DIV    = 2**24,
    parameter int unsigned SCAN_DIV     = 2**17
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,
    input  logic        flip_btn,
    input  logic        restart_btn,
    input  bounds_t     bounds,
    output pong_state_t state,
    output seg_t        segment,
    output digit_sel_t  digit_sel
);

    logic flip_pulse;
    logic restart_pulse;
    logic count_tick;
    logic scan_tick;

    button_conditioner #(
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) flip_cond_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .button (flip_btn),
        .pulse  (flip_pulse)
    );

    button_conditioner #(
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) restart_cond_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .button (restart_btn),
        .pulse  (restart_pulse)
    );

    tick_gen #(
        .COUNT_DIV (COUNT_DIV),
        .SCAN_DIV  (SCAN_DIV)
    ) tick_gen_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .count_tick (count_tick),
        .scan_tick  (scan_tick)
    );

    pong_counter pong_counter_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .count_tick    (count_tick),
        .enable        (enable),
        .flip_pulse    (flip_pulse),
        .restart_pulse (restart_pulse),
        .bounds        (bounds),
        .state         (state)
    );

    seg_scan seg_scan_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan_tick (scan_tick),
        .state     (state),
        .segment   (segment),
        .digit_sel (digit_sel)
    );

endmodule

/* hw/tick_gen.sv */
module tick_gen #(
    parameter int unsigned COUNT_DIV = 2**24,
    parameter int unsigned SCAN_DIV  = 2**17
) (
    input  logic clk,
    input  logic rst_n,
    output logic count_tick,
    output logic scan_tick
);

    localparam int unsigned COUNT_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;
    localparam int unsigned SCAN_W  = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [COUNT_W-1:0] count_cnt;
    logic [SCAN_W-1:0]  scan_cnt;

    // each tick fires on the last clock of its divider period.
    assign count_tick = (count_cnt == COUNT_W'(COUNT_DIV - 1));
    assign scan_tick  = (scan_cnt == SCAN_W'(SCAN_DIV - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_cnt <= '0;
        end else if (count_tick) begin
            count_cnt <= '0;
        end else begin
            count_cnt <= count_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_cnt <= '0;
        end else if (scan_tick) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

endmodule

/* pong_counter/pong_counter.sv */
module pong_counter
    import pong_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        count_tick,
    input  logic        enable,
    input  logic        flip_pulse,
    input  logic        restart_pulse,
    input  bounds_t     bounds,
    output pong_state_t state
);

    logic        pending;
    logic        flip_now;
    logic        in_range;
    pong_state_t next_state;

    // a flip arriving in the tick cycle itself still counts.
    assign flip_now = pending | flip_pulse;

    // stepping needs min below max and the value inside the bounds.
    assign in_range = (bounds.min < bounds.max) &&
                      (state.value >= bounds.min) &&
                      (state.value <= bounds.max);

    always_comb begin
        next_state = state;
        if (in_range) begin
            if (state.value == bounds.min) begin
                next_state.up    = 1'b1;
                next_state.value = state.value + count_t'(1);
            end else if (state.value == bounds.max) begin
                next_state.up    = 1'b0;
                next_state.value = state.value - count_t'(1);
            end else begin
                next_state.up = state.up ^ flip_now;
                if (next_state.up) begin
                    next_state.value = state.value + count_t'(1);
                end else begin
                    next_state.value = state.value - count_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= '{value: bounds.min, up: 1'b1};
            pending <= 1'b0;
        end else if (restart_pulse) begin
            // restart wins over a tick in the same cycle.
            state   <= '{value: bounds.min, up: 1'b1};
            pending <= 1'b0;
        end else if (count_tick) begin
            if (enable) begin
                state <= next_state;
            end
            pending <= 1'b0;
        end else if (flip_pulse) begin
            pending <= 1'b1;
        end
    end

    // value stays inside valid bounds across an enabled tick.
    property p_stay_in_bounds;
        @(posedge clk) disable iff (!rst_n)
        (count_tick && enable && !restart_pulse && in_range)
        |=> (state.value >= $past(bounds.min)) && (state.value <= $past(bounds.max));
    endproperty
    a_stay_in_bounds: assert property (p_stay_in_bounds)
        else $error("value left bounds after tick");

    property p_restart_to_min;
        @(posedge clk) disable iff (!rst_n)
        restart_pulse |=> (state.value == $past(bounds.min)) && state.up;
    endproperty
    a_restart_to_min: assert property (p_restart_to_min)
        else $error("restart did not return to min");

    // nothing moves the state between ticks except a restart.
    property p_hold_between_ticks;
        @(posedge clk) disable iff (!rst_n)
        (!count_tick && !restart_pulse) |=> $stable(state);
    endproperty
    a_hold_between_ticks: assert property (p_hold_between_ticks)
        else $error("state changed without tick or restart");

endmodule

/* pong_top.f */
common/pong_pkg.sv
hw/button_conditioner.sv
hw/tick_gen.sv
pong_counter/pong_counter.sv
display/seg_scan.sv
hw/pong_top.sv
test/pong_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the run from its log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert --top-module pong_tb -f pong_top.f -o pong_sim \
    > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/pong_sim > "$SIM_LOG" 2>&1 \
    || { echo "build or simulation did not complete"; cat "$BUILD_LOG"; }

grep -qx "=== PASS ===" "$SIM_LOG" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see $SIM_LOG"; exit 1; }

/* test/pong_tb.sv */
module pong_tb
    import pong_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned CLK_PERIOD    = 20;
    localparam int unsigned DEBOUNCE_LEN  = 4;
    localparam int unsigned TICK_CYCLES   = 16;
    localparam int unsigned SCAN_CYCLES   = 4;
    localparam int unsigned PRESS_CYCLES  = 7;
    localparam int unsigned RESTART_DELAY = DEBOUNCE_LEN + 2;
    localparam int unsigned MARGIN_CYCLES = 200;
    localparam int unsigned NUM_ROWS      = 16;

    // one stimulus row, lasting a whole number of count ticks.
    typedef struct packed {
        logic        enable;
        count_t      max;
        count_t      min;
        logic        flip;
        logic        restart;
        logic [31:0] ticks;
    } row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        enable;
    logic        flip_btn;
    logic        restart_btn;
    bounds_t     bounds;
    pong_state_t state;
    seg_t        segment;
    digit_sel_t  digit_sel;

    row_t        rows [NUM_ROWS];
    int unsigned num_rows = 0;
    int unsigned total_ticks = 0;
    logic        table_ready = 1'b0;
    logic [31:0] lfsr = 32'h9187d6da;

    count_t      model_value;
    logic        model_up;
    logic        model_pending;
    logic        display_check_on = 1'b0;
    int unsigned checks_due = 0;
    int unsigned checks_done = 0;
    int unsigned edge_count = 0;
    digit_sel_t  shadow_sel = 4'b1110;
    seg_t        expected_seg;
    int unsigned state_errors = 0;
    int unsigned display_errors = 0;

    pong_top #(
        .DEBOUNCE_LEN (DEBOUNCE_LEN),
        .COUNT_DIV    (TICK_CYCLES),
        .SCAN_DIV     (SCAN_CYCLES)
    ) pong_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .flip_btn    (flip_btn),
        .restart_btn (restart_btn),
        .bounds      (bounds),
        .state       (state),
        .segment     (segment),
        .digit_sel   (digit_sel)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] value);
        if (value[0]) begin
            return (value >> 1) ^ 32'h8020_0003;
        end
        return value >> 1;
    endfunction

    task automatic take_bits(input int unsigned count, output count_t bits);
        bits = '0;
        for (int unsigned i = 0; i < count; i++) begin
            bits = {bits[2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // random rows get min in 0..7 and max in 8..15.
    task automatic add_row(input logic en, input count_t max, input count_t min, input logic flip,
                           input logic restart, input logic use_random, input int unsigned ticks);
        count_t lo;
        count_t hi;
        lo = min;
        hi = max;
        if (use_random) begin
            take_bits(3, lo);
            take_bits(3, hi);
            hi = {1'b1, hi[2:0]};
        end
        rows[num_rows] = '{enable: en, max: hi, min: lo, flip: flip, restart: restart, ticks: ticks};
        total_ticks += ticks;
        num_rows++;
    endtask

    task automatic build_table();
        add_row(1'b1, 4'd5, 4'd2, 1'b0, 1'b0, 1'b0, 8);
        add_row(1'b1, 4'd5, 4'd2, 1'b1, 1'b0, 1'b0, 1);
        add_row(1'b1, 4'd5, 4'd2, 1'b0, 1'b0, 1'b0, 3);
        // flip followed by a disabled tick is dropped.
        add_row(1'b0, 4'd5, 4'd2, 1'b1, 1'b0, 1'b0, 1);
        add_row(1'b1, 4'd5, 4'd2, 1'b0, 1'b0, 1'b0, 1);
        add_row(1'b0, 4'd5, 4'd2, 1'b0, 1'b1, 1'b0, 2);
        add_row(1'b1, 4'd5, 4'd2, 1'b0, 1'b0, 1'b0, 2);
        // hold with min above max, min equal to max and a value outside.
        add_row(1'b1, 4'd3, 4'd6, 1'b0, 1'b0, 1'b0, 3);
        add_row(1'b1, 4'd4, 4'd4, 1'b0, 1'b0, 1'b0, 3);
        add_row(1'b1, 4'd12, 4'd7, 1'b0, 1'b0, 1'b0, 3);
        add_row(1'b1, 4'd12, 4'd7, 1'b0, 1'b1, 1'b0, 8);
        add_row(1'b1, 4'd12, 4'd7, 1'b1, 1'b0, 1'b0, 2);
        for (int i = 0; i < 4; i++) begin
            add_row(1'b1, 4'd0, 4'd0, 1'b0, 1'b1, 1'b1, 10);
        end
    endtask

    // step rule applied once per count tick.
    task automatic apply_tick(input logic en, input count_t max, input count_t min);
        logic hold;
        hold = (min > max) || (model_value < min) || (model_value > max) || (min == max);
        if (en && !hold) begin
            if (model_value == min) begin
                model_up    = 1'b1;
                model_value = model_value + 4'd1;
            end else if (model_value == max) begin
                model_up    = 1'b0;
                model_value = model_value - 4'd1;
            end else begin
                if (model_pending) begin
                    model_up = !model_up;
                end
                model_value = model_up ? model_value + 4'd1 : model_value - 4'd1;
            end
        end
        model_pending = 1'b0;
    endtask

    task automatic run_row(input row_t row);
        int unsigned cycles;
        cycles = row.ticks * TICK_CYCLES;
        enable      <= row.enable;
        bounds      <= '{max: row.max, min: row.min};
        flip_btn    <= row.flip;
        restart_btn <= row.restart;
        if (row.flip) begin
            model_pending = 1'b1;
        end
        for (int unsigned cyc = 1; cyc <= cycles; cyc++) begin
            @(posedge clk);
            if (cyc == PRESS_CYCLES) begin
                flip_btn    <= 1'b0;
                restart_btn <= 1'b0;
            end
            if (row.restart && cyc == RESTART_DELAY) begin
                model_value   = row.min;
                model_up      = 1'b1;
                model_pending = 1'b0;
            end
            if (cyc % TICK_CYCLES == 0) begin
                apply_tick(row.enable, row.max, row.min);
                checks_due++;
            end
        end
    endtask

    function automatic seg_t digit_pattern(input count_t digit);
        case (digit)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic seg_t expected_segment(input digit_sel_t sel, input count_t value,
                                              input logic up);
        case (sel)
            4'b1110, 4'b1101: return up ? 7'b1011100 : 7'b1100011;
            4'b1011:          return digit_pattern(value % 4'd10);
            4'b0111:          return digit_pattern(value / 4'd10);
            default:          return 7'b1111111;
        endcase
    endfunction

    task automatic check_state();
        assert (state.value == model_value) else begin
            $display("Mismatch at %0t: state.value expected %0d, actual %0d",
                     $time, model_value, state.value);
            state_errors++;
        end
        assert (state.up == model_up) else begin
            $display("Mismatch at %0t: state.up expected %0b, actual %0b",
                     $time, model_up, state.up);
            state_errors++;
        end
    endtask

    // shadow scan position, one step every SCAN_CYCLES clocks after reset.
    always @(posedge clk) begin
        if (rst_n) begin
            edge_count <= edge_count + 1;
            if (edge_count % SCAN_CYCLES == SCAN_CYCLES - 1) begin
                shadow_sel <= {shadow_sel[2:0], shadow_sel[3]};
            end
        end
    end

    always @(negedge clk) begin
        if (display_check_on) begin
            expected_seg = expected_segment(shadow_sel, model_value, model_up);
            assert (digit_sel == shadow_sel) else begin
                $display("Mismatch at %0t: digit_sel expected %b, actual %b",
                         $time, shadow_sel, digit_sel);
                display_errors++;
            end
            assert (segment == expected_seg) else begin
                $display("Mismatch at %0t: segment expected %b, actual %b",
                         $time, expected_seg, segment);
                display_errors++;
            end
        end
        if (checks_done != checks_due) begin
            check_state();
            checks_done <= checks_due;
        end
    end

    initial begin
        wait (table_ready);
        #((total_ticks * TICK_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not finish within the expected %0d ticks", total_ticks);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        build_table();
        rst_n         = 1'b0;
        enable        = 1'b0;
        flip_btn      = 1'b0;
        restart_btn   = 1'b0;
        bounds        = '{max: rows[0].max, min: rows[0].min};
        model_value   = rows[0].min;
        model_up      = 1'b1;
        model_pending = 1'b0;
        table_ready   = 1'b1;
        @(posedge clk);
        // reset state is checked like a tick.
        display_check_on = 1'b1;
        checks_due++;
        @(posedge clk);
        rst_n <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        repeat (2) @(posedge clk);
        $display("checks: %0d state, errors: %0d state, %0d display",
                 checks_done, state_errors, display_errors);
        if (state_errors == 0 && display_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
